//--- dv/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int MAX_CYCLES = 1500;

	logic      clk;
	logic      rst;
	word_t     i_addr;
	word_t     i_data;
	dbus_req_t dbus;
	word_t     d_data;
	logic      d_ack;
	logic      halted;

	word_t     rom [64];
	word_t     ram [256];
	int        prog_len;
	int        cycles;
	int        delay;
	bit        busy;
	integer    seed = 32'hf1817a1b;
	dbus_req_t last_store;

	cpu_core dut (
		.clk    (clk),
		.rst    (rst),
		.i_addr (i_addr),
		.i_data (i_data),
		.dbus   (dbus),
		.d_data (d_data),
		.d_ack  (d_ack),
		.halted (halted)
	);

	assign i_data = rom[i_addr[7:2]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			stop_on_error("Timeout: the tests did not finish in time.");
	end

	// Data RAM. Each access gets a fresh random delay of 0 to 3 cycles.
	always @(negedge clk) begin
		logic [7:0] idx;
		d_ack = 1'b0;
		if (rst) begin
			busy = 1'b0;
		end else if (dbus.access === 1'b1) begin
			if (!busy) begin
				delay = $unsigned($random(seed)) % 4;
				busy = 1'b1;
			end
			if (delay == 0) begin
				d_ack = 1'b1;
				busy = 1'b0;
				idx = dbus.addr[9:2];
				if (dbus.wr_en) begin
					ram[idx] = dbus.wr_val;
					last_store = dbus;
				end else begin
					d_data = ram[idx];
				end
			end else begin
				delay--;
			end
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bus(input string name, input dbus_req_t exp, input dbus_req_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic word_t ram_fill(input int a);
		return 32'hbad0_0000 | a;
	endfunction

	function automatic word_t enc_r(input opcode_t op, input reg_idx_t rd, input reg_idx_t ra,
				       input reg_idx_t rb);
		return {op, rd, ra, rb, 16'h0000};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input reg_idx_t rd, input reg_idx_t ra,
				       input logic [15:0] imm);
		return {op, rd, ra, 4'h0, imm};
	endfunction

	// Unused ROM words hold a halt, so a runaway program still stops.
	task automatic clear_memories();
		for (int a = 0; a < 64; a++)
			rom[a] = {HALT, 28'(a)};
		for (int a = 0; a < 256; a++)
			ram[a] = ram_fill(a);
		prog_len = 0;
	endtask

	task automatic emit(input word_t w);
		rom[prog_len] = w;
		prog_len++;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	// Older instructions may still be in memory when halted rises.
	task automatic run_to_halt();
		while (halted !== 1'b1)
			@(negedge clk);
		repeat (2) @(negedge clk);
		while (dbus.access === 1'b1)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	task automatic alu_forwarding_test();
		word_t a;
		word_t b;
		word_t e3;
		word_t e4;
		word_t e5;
		word_t e6;
		clear_memories();
		a = 100;
		b = 7;
		e3 = a + b;
		e4 = e3 - b;
		e5 = e3 & e4;
		e6 = e5 | b;
		emit(enc_i(MOVHI, 0, 0, 16'h0000));
		emit(enc_i(ADDI, 1, 0, 16'd100));
		emit(enc_i(ADDI, 2, 0, 16'd7));
		emit(enc_r(ADD, 3, 1, 2));
		emit(enc_r(SUB, 4, 3, 2));
		emit(enc_r(AND, 5, 3, 4));
		emit(enc_r(OR, 6, 5, 2));
		emit(enc_r(XOR, 7, 6, 3));
		emit(enc_r(SHL, 8, 1, 2));
		emit(enc_i(MOVHI, 9, 0, 16'h8000));
		emit(enc_r(SHR, 10, 9, 2));
		for (int r = 3; r <= 10; r++)
			emit(enc_i(STW, reg_idx_t'(r), 0, 16'(4 * r)));
		emit(enc_i(HALT, 0, 0, 16'h0000));
		apply_reset();
		run_to_halt();
		check_word("alu add", e3, ram[3]);
		check_word("alu sub", e4, ram[4]);
		check_word("alu and", e5, ram[5]);
		check_word("alu or", e6, ram[6]);
		check_word("alu xor", e6 ^ e3, ram[7]);
		check_word("alu shl", a << 7, ram[8]);
		check_word("alu movhi", 32'h8000_0000, ram[9]);
		check_word("alu shr", 32'h8000_0000 >> 7, ram[10]);
	endtask

	task automatic load_store_test();
		clear_memories();
		emit(enc_i(MOVHI, 0, 0, 16'h0000));
		emit(enc_i(ADDI, 1, 0, 16'h0111));
		emit(enc_i(ADDI, 2, 0, 16'hfffb));
		emit(enc_i(STW, 1, 0, 16'h0080));
		emit(enc_i(STW, 2, 0, 16'h0084));
		emit(enc_i(LDW, 3, 0, 16'h0080));
		emit(enc_i(LDW, 4, 0, 16'h0084));
		emit(enc_r(ADD, 5, 3, 0));
		emit(enc_r(ADD, 6, 4, 2));
		emit(enc_i(STW, 5, 0, 16'h0088));
		emit(enc_i(STW, 6, 0, 16'h008c));
		emit(enc_i(LDW, 7, 0, 16'h0090));
		emit(enc_i(ADDI, 0, 0, 16'h0000));
		emit(enc_i(STW, 7, 0, 16'h0094));
		emit(enc_i(ADDI, 8, 0, 16'h00a0));
		emit(enc_i(STW, 1, 8, 16'hfffc));
		emit(enc_i(HALT, 0, 0, 16'h0000));
		apply_reset();
		run_to_halt();
		check_word("store r1", 32'h111, ram[32'h80 >> 2]);
		check_word("store negative", -32'sd5, ram[32'h84 >> 2]);
		check_word("load then add", 32'h111, ram[32'h88 >> 2]);
		check_word("load plus reg", -32'sd10, ram[32'h8c >> 2]);
		check_word("load preset word", ram_fill(32'h90 >> 2), ram[32'h94 >> 2]);
		check_word("negative offset", 32'h111, ram[32'h9c >> 2]);
	endtask

	task automatic branch_test();
		clear_memories();
		emit(enc_i(MOVHI, 0, 0, 16'h0000));
		emit(enc_i(ADDI, 1, 0, 16'd1));
		emit(enc_i(ADDI, 2, 0, 16'd1));
		emit(enc_i(ADDI, 3, 0, 16'd2));
		emit(enc_i(ADDI, 9, 0, 16'h0055));
		emit(enc_i(BEQ, 2, 1, 16'd3));
		emit(enc_i(STW, 9, 0, 16'h0100));
		emit(enc_i(STW, 9, 0, 16'h0104));
		emit(enc_i(STW, 9, 0, 16'h0108));
		emit(enc_i(STW, 1, 0, 16'h010c));
		emit(enc_i(BNE, 2, 1, 16'd1));
		emit(enc_i(STW, 3, 0, 16'h0110));
		emit(enc_i(BEQ, 3, 1, 16'd1));
		emit(enc_i(STW, 3, 0, 16'h0114));
		emit(enc_i(BNE, 3, 1, 16'd2));
		emit(enc_i(STW, 9, 0, 16'h0118));
		emit(enc_i(STW, 9, 0, 16'h011c));
		emit(enc_i(STW, 1, 0, 16'h0120));
		emit(enc_i(HALT, 0, 0, 16'h0000));
		apply_reset();
		run_to_halt();
		for (int a = 32'h100; a <= 32'h108; a += 4)
			check_word("skipped by beq", ram_fill(a >> 2), ram[a >> 2]);
		check_word("beq target", 32'd1, ram[32'h10c >> 2]);
		check_word("bne not taken", 32'd2, ram[32'h110 >> 2]);
		check_word("beq not taken", 32'd2, ram[32'h114 >> 2]);
		check_word("skipped by bne", ram_fill(32'h118 >> 2), ram[32'h118 >> 2]);
		check_word("skipped by bne", ram_fill(32'h11c >> 2), ram[32'h11c >> 2]);
		check_word("bne target", 32'd1, ram[32'h120 >> 2]);
	endtask

	task automatic call_test();
		clear_memories();
		emit(enc_i(MOVHI, 0, 0, 16'h0000));
		emit(enc_i(ADDI, 9, 0, 16'h0077));
		emit(enc_i(JAL, 5, 0, 16'd2));
		emit(enc_i(STW, 9, 0, 16'h0200));
		emit(enc_i(STW, 9, 0, 16'h0204));
		emit(enc_i(STW, 5, 0, 16'h0208));
		emit(enc_i(ADDI, 6, 0, 16'h0033));
		emit(enc_i(STW, 6, 0, 16'h020c));
		emit(enc_i(HALT, 0, 0, 16'h0000));
		apply_reset();
		run_to_halt();
		check_word("jal skip", ram_fill(32'h200 >> 2), ram[32'h200 >> 2]);
		check_word("jal skip", ram_fill(32'h204 >> 2), ram[32'h204 >> 2]);
		check_word("jal link", 2 * 4 + 4, ram[32'h208 >> 2]);
		check_word("jal target code", 32'h33, ram[32'h20c >> 2]);
	endtask

	task automatic reset_halt_test();
		word_t held;
		dbus_req_t exp;
		clear_memories();
		emit(enc_i(MOVHI, 0, 0, 16'h0000));
		emit(enc_i(ADDI, 1, 0, 16'h005a));
		emit(enc_i(STW, 1, 0, 16'h0300));
		emit(enc_i(HALT, 0, 0, 16'h0000));
		apply_reset();
		check_word("reset i_addr", RESET_PC, i_addr);
		check_flag("reset access", 1'b0, dbus.access);
		check_flag("reset halted", 1'b0, halted);
		run_to_halt();
		exp.addr = 32'h300;
		exp.wr_en = 1'b1;
		exp.wr_val = 32'h5a;
		exp.access = 1'b1;
		check_bus("store request", exp, last_store);
		held = i_addr;
		repeat (20) begin
			@(negedge clk);
			check_word("halted i_addr", held, i_addr);
			check_flag("halted access", 1'b0, dbus.access);
			check_flag("halted stays", 1'b1, halted);
		end
	endtask

	initial begin
		rst = 1'b1;
		d_ack = 1'b0;
		d_data = '0;
		cycles = 0;
		busy = 1'b0;
		delay = 0;
		clear_memories();
		alu_forwarding_test();
		load_store_test();
		branch_test();
		call_test();
		reset_halt_test();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module cpu_core_tb -o cpu_core_sim \
	&& ./obj_dir/cpu_core_sim \
	|| exit 1

//--- source/cpu_core.sv
`default_nettype none

module cpu_core (
	input  logic                    clk,
	input  logic                    rst,
	output cpu_isa_pkg::word_t      i_addr,
	input  cpu_isa_pkg::word_t      i_data,
	output cpu_pipe_pkg::dbus_req_t dbus,
	input  cpu_isa_pkg::word_t      d_data,
	input  logic                    d_ack,
	output logic                    halted
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic     stall;
	logic     flush;
	logic     branch_taken;
	word_t    branch_pc;
	logic     halt_seen;
	instr_t   fd_instr;
	logic     fd_valid;
	word_t    fd_pc_plus_4;
	reg_idx_t d_ra_sel;
	reg_idx_t d_rb_sel;
	reg_idx_t e_ra_sel;
	reg_idx_t e_rb_sel;
	de_t      de;
	word_t    ra;
	word_t    rb;
	word_t    op_a;
	word_t    op_b;
	em_t      em;
	mw_t      mw;

	// The youngest result wins, so execute output beats the writeback value.
	function automatic word_t fwd_operand(input reg_idx_t sel, input word_t rf_val,
					      input em_t em_q, input mw_t mw_q);
		if (em_q.update_rd && em_q.rd == sel)
			return em_q.alu_out;
		else if (mw_q.update_rd && mw_q.rd == sel)
			return mw_q.wr_val;
		return rf_val;
	endfunction

	assign op_a = fwd_operand(e_ra_sel, ra, em, mw);
	assign op_b = fwd_operand(e_rb_sel, rb, em, mw);

	// Decode is cleared behind a taken branch and behind a halt.
	assign flush = branch_taken || halt_seen;
	assign halted = halt_seen;

	cpu_fetch fetch (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.branch_taken (branch_taken),
		.branch_pc    (branch_pc),
		.halt_seen    (halt_seen),
		.i_addr       (i_addr),
		.i_data       (i_data),
		.instr        (fd_instr),
		.instr_valid  (fd_valid),
		.pc_plus_4    (fd_pc_plus_4)
	);

	cpu_decode decode (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.flush       (flush),
		.instr       (fd_instr),
		.instr_valid (fd_valid),
		.pc_plus_4   (fd_pc_plus_4),
		.ra_sel      (d_ra_sel),
		.rb_sel      (d_rb_sel),
		.e_ra_sel    (e_ra_sel),
		.e_rb_sel    (e_rb_sel),
		.de          (de)
	);

	cpu_regfile regfile (
		.clk    (clk),
		.ra_sel (d_ra_sel),
		.rb_sel (d_rb_sel),
		.ra     (ra),
		.rb     (rb),
		.mw     (mw)
	);

	cpu_exec execute (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.de           (de),
		.op_a         (op_a),
		.op_b         (op_b),
		.em           (em),
		.branch_taken (branch_taken),
		.branch_pc    (branch_pc),
		.halt_seen    (halt_seen)
	);

	cpu_memory mem (
		.clk    (clk),
		.rst    (rst),
		.em     (em),
		.dbus   (dbus),
		.d_data (d_data),
		.d_ack  (d_ack),
		.stall  (stall),
		.mw     (mw)
	);

endmodule

`default_nettype wire

//--- source/cpu_decode.sv
`default_nettype none

module cpu_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  flush,
	input  cpu_isa_pkg::instr_t   instr,
	input  logic                  instr_valid,
	input  cpu_isa_pkg::word_t    pc_plus_4,
	output cpu_isa_pkg::reg_idx_t ra_sel,
	output cpu_isa_pkg::reg_idx_t rb_sel,
	output cpu_isa_pkg::reg_idx_t e_ra_sel,
	output cpu_isa_pkg::reg_idx_t e_rb_sel,
	output cpu_pipe_pkg::de_t     de
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	opcode_t  opcode;
	reg_idx_t sel_a;
	reg_idx_t sel_b;
	word_t    imm_sext;
	de_t      dec;

	assign opcode = instr.r.opcode;
	assign imm_sext = {{16{instr.i.imm16[15]}}, instr.i.imm16};

	// Stores and branches name their second source in the rd field.
	always_comb begin
		sel_a = instr.r.ra;
		if (opcode == STW || opcode == BEQ || opcode == BNE)
			sel_b = instr.r.rd;
		else
			sel_b = instr.r.rb;
	end

	// While stalled the register file keeps reading the operands of the
	// instruction that waits in execute.
	assign ra_sel = stall ? e_ra_sel : sel_a;
	assign rb_sel = stall ? e_rb_sel : sel_b;

	always_comb begin
		dec = '0;
		dec.valid = 1'b1;
		dec.alu_op = ALU_ADD;
		dec.imm32 = imm_sext;
		dec.rd = instr.r.rd;
		dec.branch = BR_NONE;
		dec.pc_plus_4 = pc_plus_4;
		case (opcode)
			ADD, SUB, AND, OR, XOR, SHL, SHR: begin
				dec.alu_op = alu_op_t'(opcode[2:0]);
				dec.update_rd = 1'b1;
			end
			ADDI: begin
				dec.use_imm = 1'b1;
				dec.update_rd = 1'b1;
			end
			MOVHI: begin
				dec.alu_op = ALU_PASS_B;
				dec.use_imm = 1'b1;
				dec.imm32 = {instr.i.imm16, 16'h0000};
				dec.update_rd = 1'b1;
			end
			LDW: begin
				dec.use_imm = 1'b1;
				dec.mem_load = 1'b1;
				dec.update_rd = 1'b1;
			end
			STW: begin
				dec.use_imm = 1'b1;
				dec.mem_store = 1'b1;
			end
			BEQ: dec.branch = BR_EQ;
			BNE: dec.branch = BR_NE;
			JAL: begin
				dec.branch = BR_ALWAYS;
				dec.is_call = 1'b1;
				dec.update_rd = 1'b1;
			end
			HALT: dec.halt = 1'b1;
			default: dec.valid = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			de <= '0;
		end else if (!stall) begin
			if (instr_valid && !flush)
				de <= dec;
			else
				de <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			e_ra_sel <= sel_a;
			e_rb_sel <= sel_b;
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_exec.sv
`default_nettype none

module cpu_exec (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  cpu_pipe_pkg::de_t  de,
	input  cpu_isa_pkg::word_t op_a,
	input  cpu_isa_pkg::word_t op_b,
	output cpu_pipe_pkg::em_t  em,
	output logic               branch_taken,
	output cpu_isa_pkg::word_t branch_pc,
	output logic               halt_seen
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	word_t alu_b;
	word_t alu_out;
	logic  cond_met;
	logic  halt_q;

	assign alu_b = de.use_imm ? de.imm32 : op_b;

	always_comb begin
		case (de.alu_op)
			ALU_ADD: alu_out = op_a + alu_b;
			ALU_SUB: alu_out = op_a - alu_b;
			ALU_AND: alu_out = op_a & alu_b;
			ALU_OR:  alu_out = op_a | alu_b;
			ALU_XOR: alu_out = op_a ^ alu_b;
			ALU_SHL: alu_out = op_a << alu_b[4:0];
			ALU_SHR: alu_out = op_a >> alu_b[4:0];
			default: alu_out = alu_b;
		endcase
	end

	always_comb begin
		case (de.branch)
			BR_EQ:     cond_met = (op_a == op_b);
			BR_NE:     cond_met = (op_a != op_b);
			BR_ALWAYS: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	// Branch offsets count words from the instruction after the branch.
	assign branch_taken = de.valid && cond_met;
	assign branch_pc = de.pc_plus_4 + {de.imm32[29:0], 2'b00};

	// Once a halt has been executed the core stays halted until reset.
	assign halt_seen = halt_q || (de.valid && de.halt);

	always_ff @(posedge clk) begin
		if (rst)
			halt_q <= 1'b0;
		else if (de.valid && de.halt)
			halt_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			em.valid <= de.valid;
			em.alu_out <= de.is_call ? de.pc_plus_4 : alu_out;
			em.store_val <= op_b;
			em.mem_load <= de.valid && de.mem_load;
			em.mem_store <= de.valid && de.mem_store;
			em.rd <= de.rd;
			em.update_rd <= de.valid && de.update_rd;
		end
		if (rst) begin
			em.valid <= 1'b0;
			em.mem_load <= 1'b0;
			em.mem_store <= 1'b0;
			em.update_rd <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_fetch.sv
`default_nettype none

module cpu_fetch (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  logic                branch_taken,
	input  cpu_isa_pkg::word_t  branch_pc,
	input  logic                halt_seen,
	output cpu_isa_pkg::word_t  i_addr,
	input  cpu_isa_pkg::word_t  i_data,
	output cpu_isa_pkg::instr_t instr,
	output logic                instr_valid,
	output cpu_isa_pkg::word_t  pc_plus_4
);
	import cpu_isa_pkg::*;

	word_t pc;
	word_t pc_seq;

	assign pc_seq = pc + 32'd4;
	assign i_addr = pc;

	// A redirect drops the word being fetched this cycle, and the target
	// goes out on i_addr in the next one.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			instr_valid <= 1'b0;
		end else if (!stall) begin
			if (branch_taken) begin
				pc <= branch_pc;
				instr_valid <= 1'b0;
			end else if (halt_seen) begin
				instr_valid <= 1'b0;
			end else begin
				pc <= pc_seq;
				instr_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instr <= i_data;
			pc_plus_4 <= pc_seq;
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int NUM_REGS = 16;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// The register ALU opcodes keep the same order as alu_op_t.
	typedef enum logic [3:0] {
		ADD   = 4'h0,
		SUB   = 4'h1,
		AND   = 4'h2,
		OR    = 4'h3,
		XOR   = 4'h4,
		SHL   = 4'h5,
		SHR   = 4'h6,
		ADDI  = 4'h7,
		MOVHI = 4'h8,
		LDW   = 4'h9,
		STW   = 4'ha,
		BEQ   = 4'hb,
		BNE   = 4'hc,
		JAL   = 4'hd,
		HALT  = 4'he
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SHL    = 3'd5,
		ALU_SHR    = 3'd6,
		ALU_PASS_B = 3'd7
	} alu_op_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [15:0] unused;
	} instr_r_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		logic [3:0]  unused;
		logic [15:0] imm16;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_t;

endpackage

`default_nettype wire

//--- source/cpu_memory.sv
`default_nettype none

module cpu_memory (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_pipe_pkg::em_t       em,
	output cpu_pipe_pkg::dbus_req_t dbus,
	input  cpu_isa_pkg::word_t      d_data,
	input  logic                    d_ack,
	output logic                    stall,
	output cpu_pipe_pkg::mw_t       mw
);
	logic mem_op;

	assign mem_op = em.valid && (em.mem_load || em.mem_store);

	// The execute register is frozen during a stall, so the request stays
	// stable until the cycle that sees d_ack.
	always_comb begin
		dbus.addr = em.alu_out;
		dbus.wr_en = em.valid && em.mem_store;
		dbus.wr_val = em.store_val;
		dbus.access = mem_op;
	end

	assign stall = mem_op && !d_ack;

	always_ff @(posedge clk) begin
		mw.rd <= em.rd;
		if (em.mem_load)
			mw.wr_val <= d_data;
		else
			mw.wr_val <= em.alu_out;

		// A pending access sends a bubble down to writeback.
		if (rst || stall)
			mw.update_rd <= 1'b0;
		else
			mw.update_rd <= em.update_rd;
	end

endmodule

`default_nettype wire

//--- source/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

	typedef enum logic [1:0] {
		BR_NONE   = 2'd0,
		BR_EQ     = 2'd1,
		BR_NE     = 2'd2,
		BR_ALWAYS = 2'd3
	} branch_t;

	typedef struct packed {
		logic                  valid;
		cpu_isa_pkg::alu_op_t  alu_op;
		logic                  use_imm;
		cpu_isa_pkg::word_t    imm32;
		cpu_isa_pkg::reg_idx_t rd;
		logic                  update_rd;
		logic                  mem_load;
		logic                  mem_store;
		branch_t               branch;
		logic                  is_call;
		logic                  halt;
		cpu_isa_pkg::word_t    pc_plus_4;
	} de_t;

	// For loads and stores alu_out carries the memory address.
	typedef struct packed {
		logic                  valid;
		cpu_isa_pkg::word_t    alu_out;
		cpu_isa_pkg::word_t    store_val;
		logic                  mem_load;
		logic                  mem_store;
		cpu_isa_pkg::reg_idx_t rd;
		logic                  update_rd;
	} em_t;

	typedef struct packed {
		cpu_isa_pkg::reg_idx_t rd;
		logic                  update_rd;
		cpu_isa_pkg::word_t    wr_val;
	} mw_t;

	typedef struct packed {
		cpu_isa_pkg::word_t addr;
		logic               wr_en;
		cpu_isa_pkg::word_t wr_val;
		logic               access;
	} dbus_req_t;

endpackage

`default_nettype wire

//--- source/cpu_regfile.sv
`default_nettype none

module cpu_regfile (
	input  logic                  clk,
	input  cpu_isa_pkg::reg_idx_t ra_sel,
	input  cpu_isa_pkg::reg_idx_t rb_sel,
	output cpu_isa_pkg::word_t    ra,
	output cpu_isa_pkg::word_t    rb,
	input  cpu_pipe_pkg::mw_t     mw
);
	import cpu_isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (mw.update_rd)
			regs[mw.rd] <= mw.wr_val;
	end

	// The value being written this cycle wins over the stored one.
	always_ff @(posedge clk) begin
		if (mw.update_rd && mw.rd == ra_sel)
			ra <= mw.wr_val;
		else
			ra <= regs[ra_sel];

		if (mw.update_rd && mw.rd == rb_sel)
			rb <= mw.wr_val;
		else
			rb <= regs[rb_sel];
	end

endmodule

`default_nettype wire

//--- vlog.f
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/cpu_fetch.sv
source/cpu_decode.sv
source/cpu_regfile.sv
source/cpu_exec.sv
source/cpu_memory.sv
source/cpu_core.sv
dv/cpu_core_tb.sv
